//--- build.f
rtl/ex_pkg.sv
rtl/ex_result_if.sv
rtl/ex_alu.sv
rtl/ex_mul.sv
rtl/ex_hilo.sv
rtl/ex_stage.sv
rtl/ex_mem_reg.sv
rtl/mips_ex_top.sv
tests/ex_assertions.sv
tests/ex_checker.sv
tests/tb_mips_ex_top.sv

//--- rtl/ex_alu.sv
`timescale 1ns/1ns
`default_nettype none

module ex_alu (
    input  ex_pkg::aluop_t aluop_i,
    input  ex_pkg::word_t  reg1_i,
    input  ex_pkg::word_t  reg2_i,
    output ex_pkg::word_t  logic_o,
    output ex_pkg::word_t  shift_o,
    output ex_pkg::word_t  arith_o,
    output logic           ov_o
);

    logic [ex_pkg::SHAMT_W-1:0] shamt;
    logic                       sub_op;
    logic                       b_sign;
    ex_pkg::word_t              reg2_mux;
    ex_pkg::word_t              sum;
    logic                       lt_signed;
    logic                       lt_unsigned;

    function automatic ex_pkg::word_t lead_zeros(input ex_pkg::word_t w);
        ex_pkg::word_t n;
        logic          hit;
        n   = '0;
        hit = 1'b0;
        for (int i = ex_pkg::WORD_W - 1; i >= 0; i--) begin
            hit = hit | w[i];
            if (!hit) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign shamt = reg1_i[ex_pkg::SHAMT_W-1:0];  // low bits of operand 1

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_OR:  logic_o = reg1_i | reg2_i;
            ex_pkg::OP_AND: logic_o = reg1_i & reg2_i;
            ex_pkg::OP_NOR: logic_o = ~(reg1_i | reg2_i);
            ex_pkg::OP_XOR: logic_o = reg1_i ^ reg2_i;
            default:        logic_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_SLL: shift_o = reg2_i << shamt;
            ex_pkg::OP_SRL: shift_o = reg2_i >> shamt;
            ex_pkg::OP_SRA: shift_o = ex_pkg::word_t'($signed(reg2_i) >>> shamt);
            default:        shift_o = '0;
        endcase
    end

    // single adder, subtract and slt feed in -reg2
    assign sub_op = (aluop_i == ex_pkg::OP_SUB) || (aluop_i == ex_pkg::OP_SUBU) ||
                    (aluop_i == ex_pkg::OP_SLT);
    assign reg2_mux = sub_op ? (~reg2_i) + 1'b1 : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    // sign of the effective operand, still right for reg2 = 0x80000000
    assign b_sign = sub_op ? ~reg2_i[ex_pkg::WORD_W-1] : reg2_i[ex_pkg::WORD_W-1];
    assign ov_o   = (reg1_i[ex_pkg::WORD_W-1] == b_sign) &&
                    (sum[ex_pkg::WORD_W-1] != reg1_i[ex_pkg::WORD_W-1]);

    // mixed signs decide directly, else the difference sign does
    assign lt_signed = (reg1_i[ex_pkg::WORD_W-1] != reg2_i[ex_pkg::WORD_W-1]) ?
                       reg1_i[ex_pkg::WORD_W-1] : sum[ex_pkg::WORD_W-1];
    assign lt_unsigned = reg1_i < reg2_i;

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_SLT:  arith_o = ex_pkg::word_t'(lt_signed);
            ex_pkg::OP_SLTU: arith_o = ex_pkg::word_t'(lt_unsigned);
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU, ex_pkg::OP_ADDI, ex_pkg::OP_ADDIU,
            ex_pkg::OP_SUB, ex_pkg::OP_SUBU: begin
                arith_o = sum;
            end
            ex_pkg::OP_CLZ:  arith_o = lead_zeros(reg1_i);
            ex_pkg::OP_CLO:  arith_o = lead_zeros(~reg1_i);  // leading ones
            default:         arith_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ex_hilo.sv
`timescale 1ns/1ns
`default_nettype none

module ex_hilo (
    input  logic           clk,
    input  logic           rst_i,
    input  ex_pkg::aluop_t aluop_i,
    input  ex_pkg::word_t  reg1_i,
    input  ex_pkg::dword_t product_i,
    ex_result_if.dst       mem_i,
    output ex_pkg::word_t  move_o,
    output logic           whilo_o,
    output ex_pkg::word_t  hi_o,
    output ex_pkg::word_t  lo_o,
    output ex_pkg::word_t  hi_reg_o,
    output ex_pkg::word_t  lo_reg_o
);

    ex_pkg::word_t hi_q;
    ex_pkg::word_t lo_q;
    ex_pkg::word_t hi_cur;
    ex_pkg::word_t lo_cur;

    // written at the end of MEM
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (mem_i.whilo) begin
            hi_q <= mem_i.hi;
            lo_q <= mem_i.lo;
        end
    end

    assign hi_reg_o = hi_q;
    assign lo_reg_o = lo_q;

    // a pending write in MEM is newer than the register
    assign hi_cur = mem_i.whilo ? mem_i.hi : hi_q;
    assign lo_cur = mem_i.whilo ? mem_i.lo : lo_q;

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_MFHI:                 move_o = hi_cur;
            ex_pkg::OP_MFLO:                 move_o = lo_cur;
            ex_pkg::OP_MOVZ, ex_pkg::OP_MOVN: move_o = reg1_i;  // condition settled in ID
            default:                         move_o = '0;
        endcase
    end

    // write request, the untouched half keeps its current value
    always_comb begin
        case (aluop_i)
            ex_pkg::OP_MULT, ex_pkg::OP_MULTU: begin
                whilo_o = 1'b1;
                hi_o    = product_i[2*ex_pkg::WORD_W-1:ex_pkg::WORD_W];
                lo_o    = product_i[ex_pkg::WORD_W-1:0];
            end
            ex_pkg::OP_MTHI: begin
                whilo_o = 1'b1;
                hi_o    = reg1_i;
                lo_o    = lo_cur;
            end
            ex_pkg::OP_MTLO: begin
                whilo_o = 1'b1;
                hi_o    = hi_cur;
                lo_o    = reg1_i;
            end
            default: begin
                whilo_o = 1'b0;
                hi_o    = '0;
                lo_o    = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ex_mem_reg.sv
`timescale 1ns/1ns
`default_nettype none

module ex_mem_reg (
    input  logic     clk,
    input  logic     rst_i,
    ex_result_if.dst ex_i,
    ex_result_if.src mem_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            // no write enable may leave reset
            mem_o.wd    <= '0;
            mem_o.wreg  <= 1'b0;
            mem_o.wdata <= '0;
            mem_o.whilo <= 1'b0;
            mem_o.hi    <= '0;
            mem_o.lo    <= '0;
        end else begin
            mem_o.wd    <= ex_i.wd;
            mem_o.wreg  <= ex_i.wreg;
            mem_o.wdata <= ex_i.wdata;
            mem_o.whilo <= ex_i.whilo;
            mem_o.hi    <= ex_i.hi;
            mem_o.lo    <= ex_i.lo;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ex_mul.sv
`timescale 1ns/1ns
`default_nettype none

module ex_mul (
    input  ex_pkg::aluop_t aluop_i,
    input  ex_pkg::word_t  reg1_i,
    input  ex_pkg::word_t  reg2_i,
    output ex_pkg::dword_t product_o
);

    logic           is_signed;
    logic           neg_result;
    ex_pkg::word_t  op1;
    ex_pkg::word_t  op2;
    ex_pkg::dword_t mag;

    assign is_signed = (aluop_i == ex_pkg::OP_MUL) || (aluop_i == ex_pkg::OP_MULT);

    // magnitudes for signed ops, raw words for multu
    assign op1 = (is_signed && reg1_i[ex_pkg::WORD_W-1]) ? (~reg1_i) + 1'b1 : reg1_i;
    assign op2 = (is_signed && reg2_i[ex_pkg::WORD_W-1]) ? (~reg2_i) + 1'b1 : reg2_i;

    assign mag = ex_pkg::dword_t'(op1) * ex_pkg::dword_t'(op2);

    assign neg_result = is_signed &&
                        (reg1_i[ex_pkg::WORD_W-1] ^ reg2_i[ex_pkg::WORD_W-1]);

    assign product_o = neg_result ? (~mag) + 1'b1 : mag;  // fix sign back up

endmodule

`default_nettype wire

//--- rtl/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [2*WORD_W-1:0]   dword_t;   // hi in upper half
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // codes follow the decoder of the core, test data uses the same values
    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_SRL   = 8'h02,
        OP_SRA   = 8'h03,
        OP_MOVZ  = 8'h0a,
        OP_MOVN  = 8'h0b,
        OP_MFHI  = 8'h10,
        OP_MTHI  = 8'h11,
        OP_MFLO  = 8'h12,
        OP_MTLO  = 8'h13,
        OP_MULT  = 8'h18,
        OP_MULTU = 8'h19,
        OP_ADD   = 8'h20,
        OP_ADDU  = 8'h21,
        OP_SUB   = 8'h22,
        OP_SUBU  = 8'h23,
        OP_AND   = 8'h24,
        OP_OR    = 8'h25,
        OP_XOR   = 8'h26,
        OP_NOR   = 8'h27,
        OP_SLT   = 8'h2a,
        OP_SLTU  = 8'h2b,
        OP_ADDI  = 8'h55,
        OP_ADDIU = 8'h56,
        OP_SLL   = 8'h7c,
        OP_MUL   = 8'ha9,
        OP_CLZ   = 8'hb0,
        OP_CLO   = 8'hb1
    } aluop_t;

    // result class, picks which unit feeds wdata
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alusel_t;

endpackage

`default_nettype wire

//--- rtl/ex_result_if.sv
`timescale 1ns/1ns
`default_nettype none

// one EX result heading into MEM
interface ex_result_if;

    ex_pkg::reg_addr_t wd;     // destination register
    logic              wreg;   // register write enable
    ex_pkg::word_t     wdata;
    logic              whilo;  // hi/lo write enable
    ex_pkg::word_t     hi;
    ex_pkg::word_t     lo;

    modport src (
        output wd, wreg, wdata, whilo, hi, lo
    );

    modport dst (
        input wd, wreg, wdata, whilo, hi, lo
    );

endinterface

`default_nettype wire

//--- rtl/ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
    input  logic              clk,
    input  logic              rst_i,
    input  ex_pkg::aluop_t    aluop_i,
    input  ex_pkg::alusel_t   alusel_i,
    input  ex_pkg::word_t     reg1_i,
    input  ex_pkg::word_t     reg2_i,
    input  ex_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    ex_result_if.dst          mem_i,
    ex_result_if.src          res_o,
    output ex_pkg::word_t     hi_reg_o,
    output ex_pkg::word_t     lo_reg_o
);

    ex_pkg::word_t  logic_res;
    ex_pkg::word_t  shift_res;
    ex_pkg::word_t  arith_res;
    ex_pkg::word_t  move_res;
    ex_pkg::dword_t product;
    logic           ov;
    logic           ov_op;
    logic           whilo;
    ex_pkg::word_t  hi_req;
    ex_pkg::word_t  lo_req;

    ex_alu ex_alu_inst (
        .aluop_i (aluop_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .logic_o (logic_res),
        .shift_o (shift_res),
        .arith_o (arith_res),
        .ov_o    (ov)
    );

    ex_mul ex_mul_inst (
        .aluop_i   (aluop_i),
        .reg1_i    (reg1_i),
        .reg2_i    (reg2_i),
        .product_o (product)
    );

    ex_hilo ex_hilo_inst (
        .clk       (clk),
        .rst_i     (rst_i),
        .aluop_i   (aluop_i),
        .reg1_i    (reg1_i),
        .product_i (product),
        .mem_i     (mem_i),
        .move_o    (move_res),
        .whilo_o   (whilo),
        .hi_o      (hi_req),
        .lo_o      (lo_req),
        .hi_reg_o  (hi_reg_o),
        .lo_reg_o  (lo_reg_o)
    );

    always_comb begin
        case (alusel_i)
            ex_pkg::SEL_LOGIC: res_o.wdata = logic_res;
            ex_pkg::SEL_SHIFT: res_o.wdata = shift_res;
            ex_pkg::SEL_ARITH: res_o.wdata = arith_res;
            ex_pkg::SEL_MOVE:  res_o.wdata = move_res;
            ex_pkg::SEL_MUL:   res_o.wdata = product[ex_pkg::WORD_W-1:0];  // mul keeps low word
            default:           res_o.wdata = '0;
        endcase
    end

    // only the trapping adds drop their write on overflow
    assign ov_op = (aluop_i == ex_pkg::OP_ADD) || (aluop_i == ex_pkg::OP_ADDI) ||
                   (aluop_i == ex_pkg::OP_SUB);

    assign res_o.wd    = wd_i;
    assign res_o.wreg  = wreg_i && !(ov_op && ov);
    assign res_o.whilo = whilo;
    assign res_o.hi    = hi_req;
    assign res_o.lo    = lo_req;

endmodule

`default_nettype wire

//--- rtl/mips_ex_top.sv
`timescale 1ns/1ns
`default_nettype none

module mips_ex_top (
    input  logic              clk,
    input  logic              rst_i,
    input  ex_pkg::aluop_t    aluop_i,
    input  ex_pkg::alusel_t   alusel_i,
    input  ex_pkg::word_t     reg1_i,
    input  ex_pkg::word_t     reg2_i,
    input  ex_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    output ex_pkg::reg_addr_t mem_wd_o,
    output logic              mem_wreg_o,
    output ex_pkg::word_t     mem_wdata_o,
    output ex_pkg::word_t     hi_o,
    output ex_pkg::word_t     lo_o
);

    ex_result_if ex_res ();
    ex_result_if mem_res ();  // also the hi/lo forwarding path

    ex_stage ex_stage_inst (
        .clk      (clk),
        .rst_i    (rst_i),
        .aluop_i  (aluop_i),
        .alusel_i (alusel_i),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .wd_i     (wd_i),
        .wreg_i   (wreg_i),
        .mem_i    (mem_res.dst),
        .res_o    (ex_res.src),
        .hi_reg_o (hi_o),
        .lo_reg_o (lo_o)
    );

    ex_mem_reg ex_mem_reg_inst (
        .clk   (clk),
        .rst_i (rst_i),
        .ex_i  (ex_res.dst),
        .mem_o (mem_res.src)
    );

    assign mem_wd_o    = mem_res.wd;
    assign mem_wreg_o  = mem_res.wreg;
    assign mem_wdata_o = mem_res.wdata;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/bash
# builds with Verilator from build.f, runs, then scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_mips_ex_top --Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0

//--- tests/ex_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module ex_assertions (
    input logic              clk,
    input logic              rst_i,
    input ex_pkg::reg_addr_t wd_i,
    input logic              wreg_i,
    input ex_pkg::reg_addr_t mem_wd_o,
    input logic              mem_wreg_o,
    input ex_pkg::word_t     hi_o,
    input ex_pkg::word_t     lo_o
);

    int fail_count;  // failed assertions so far

    initial fail_count = 0;

    // nothing may be written straight out of reset
    reset_clears: assert property (@(posedge clk)
        rst_i |=> (!mem_wreg_o && hi_o == '0 && lo_o == '0))
        else begin
            $error("pipeline outputs not cleared after reset");
            fail_count++;
        end

    wd_follows: assert property (@(posedge clk)
        !rst_i |=> (mem_wd_o == $past(wd_i)))
        else begin
            $error("mem_wd_o does not match wd_i of the previous edge");
            fail_count++;
        end

    wreg_needs_request: assert property (@(posedge clk)
        mem_wreg_o |-> $past(wreg_i))
        else begin
            $error("mem_wreg_o set without wreg_i one edge earlier");
            fail_count++;
        end

endmodule

bind mips_ex_top ex_assertions ex_assertions_inst (.*);

`default_nettype wire

//--- tests/ex_checker.sv
`timescale 1ns/1ns
`default_nettype none

module ex_checker (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              vec_valid_i,
    input  int                vec_id_i,     // negative for nop gaps
    input  ex_pkg::reg_addr_t exp_wd_i,
    input  ex_pkg::word_t     exp_wdata_i,
    input  logic              exp_wreg_i,
    input  logic              exp_hilo_i,
    input  ex_pkg::word_t     exp_hi_i,
    input  ex_pkg::word_t     exp_lo_i,
    input  ex_pkg::reg_addr_t mem_wd_i,
    input  logic              mem_wreg_i,
    input  ex_pkg::word_t     mem_wdata_i,
    input  ex_pkg::word_t     hi_i,
    input  ex_pkg::word_t     lo_i,
    output int                err_count_o,
    output int                done_count_o
);

    typedef struct {
        int                id;
        ex_pkg::reg_addr_t wd;
        ex_pkg::word_t     wdata;
        logic              wreg;
        logic              hilo;
        ex_pkg::word_t     hi;
        ex_pkg::word_t     lo;
        logic              bad;
    } exp_t;

    exp_t          exp_q[$];   // sampled, waiting for MEM
    exp_t          hl_q[$];    // waiting for the hi/lo register
    exp_t          cap;
    exp_t          cur;
    ex_pkg::word_t last_hi;
    ex_pkg::word_t last_lo;
    logic          miss;

    initial begin
        err_count_o  = 0;
        done_count_o = 0;
    end

    task automatic check_field(input string what, input logic [31:0] got,
                               input logic [31:0] exp, input int id, output logic bad);
        bad = (got !== exp);
        if (bad) begin
            err_count_o = err_count_o + 1;
            $display("FAILED at %0t ns: vector %0d %s is %h, expected %h",
                     $time, id, what, got, exp);
        end
    endtask

    task automatic finish_vector(input exp_t e);
        if (e.id >= 0) begin
            done_count_o = done_count_o + 1;
            if (e.bad) $display("vector %0d: mismatch", e.id);
            else $display("vector %0d: ok", e.id);
        end
    endtask

    // inputs are stable here, they change on the falling edge
    always @(posedge clk) begin
        if (!rst_i && vec_valid_i) begin
            cap.id    = vec_id_i;
            cap.wd    = exp_wd_i;
            cap.wdata = exp_wdata_i;
            cap.wreg  = exp_wreg_i;
            cap.hilo  = exp_hilo_i;
            cap.hi    = exp_hi_i;
            cap.lo    = exp_lo_i;
            cap.bad   = 1'b0;
            exp_q.push_back(cap);
        end
    end

    always @(negedge clk) begin
        if (rst_i) begin
            last_hi = '0;
            last_lo = '0;
        end else begin
            if (hl_q.size() > 0) begin
                cur = hl_q.pop_front();
                check_field("hi_o", hi_i, cur.hi, cur.id, miss);
                cur.bad = cur.bad | miss;
                check_field("lo_o", lo_i, cur.lo, cur.id, miss);
                cur.bad = cur.bad | miss;
                last_hi = cur.hi;
                last_lo = cur.lo;
                finish_vector(cur);
            end else begin
                // no write landed, so hi/lo must hold
                check_field("held hi_o", hi_i, last_hi, -1, miss);
                check_field("held lo_o", lo_i, last_lo, -1, miss);
            end
            if (exp_q.size() > 0) begin
                cur = exp_q.pop_front();
                check_field("mem_wd_o", 32'(mem_wd_i), 32'(cur.wd), cur.id, miss);
                cur.bad = cur.bad | miss;
                check_field("mem_wreg_o", 32'(mem_wreg_i), 32'(cur.wreg), cur.id, miss);
                cur.bad = cur.bad | miss;
                check_field("mem_wdata_o", mem_wdata_i, cur.wdata, cur.id, miss);
                cur.bad = cur.bad | miss;
                if (cur.hilo) hl_q.push_back(cur);
                else finish_vector(cur);
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/ex_testdata.hex
// aluop alusel reg1 reg2 wd wreg | exp_wdata exp_wreg hilo_changes exp_hi exp_lo
// hex fields, alusel/wreg/flags one digit, wd two digits
25 1 f0f0f0f0 0ff00ff0 01 1 fff0fff0 1 0 00000000 00000000
24 1 f0f0f0f0 0ff00ff0 02 1 00f000f0 1 0 00000000 00000000
27 1 f0f0f0f0 0ff00ff0 03 1 000f000f 1 0 00000000 00000000
26 1 f0f0f0f0 0ff00ff0 04 1 ff00ff00 1 0 00000000 00000000
7c 2 00000001 80000001 05 1 00000002 1 0 00000000 00000000
02 2 0000001f 80000000 06 1 00000001 1 0 00000000 00000000
03 2 0000001f 80000000 07 1 ffffffff 1 0 00000000 00000000
03 2 00000001 f0000000 08 1 f8000000 1 0 00000000 00000000
03 2 00000020 80000000 09 1 80000000 1 0 00000000 00000000
20 4 7fffffff 00000001 0b 1 80000000 0 0 00000000 00000000
21 4 7fffffff 00000001 0c 1 80000000 1 0 00000000 00000000
55 4 80000000 ffffffff 0d 1 7fffffff 0 0 00000000 00000000
56 4 80000000 ffffffff 0e 1 7fffffff 1 0 00000000 00000000
22 4 80000000 00000001 0f 1 7fffffff 0 0 00000000 00000000
22 4 00000000 80000000 10 1 80000000 0 0 00000000 00000000
23 4 00000003 00000005 11 1 fffffffe 1 0 00000000 00000000
2a 4 ffffffff 00000001 12 1 00000001 1 0 00000000 00000000
2b 4 ffffffff 00000001 13 1 00000000 1 0 00000000 00000000
b0 4 00000000 00000000 14 1 00000020 1 0 00000000 00000000
b1 4 ffffffff 00000000 15 1 00000020 1 0 00000000 00000000
b1 4 80000000 00000000 16 1 00000001 1 0 00000000 00000000
a9 5 fffffffe 00000003 1a 1 fffffffa 1 0 00000000 00000000
18 0 fffffffe 00000003 1b 0 00000000 0 1 ffffffff fffffffa
10 3 00000000 00000000 1c 1 ffffffff 1 0 00000000 00000000
19 0 fffffffe 00000003 1d 0 00000000 0 1 00000002 fffffffa
12 3 00000000 00000000 1e 1 fffffffa 1 0 00000000 00000000
11 0 12345678 00000000 00 0 00000000 0 1 12345678 fffffffa
10 3 00000000 00000000 1f 1 12345678 1 0 00000000 00000000
13 0 cafef00d 00000000 00 0 00000000 0 1 12345678 cafef00d

//--- tests/tb_mips_ex_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_ex_top;

    localparam int NUM_VEC    = 29;
    localparam int RST_CYCLES = 16;
    localparam int MAX_CYCLES = RST_CYCLES + 3 * NUM_VEC + 20;
    localparam int SEED       = 88618;

    logic              clk;
    logic              rst_i;
    ex_pkg::aluop_t    aluop_i;
    ex_pkg::alusel_t   alusel_i;
    ex_pkg::word_t     reg1_i;
    ex_pkg::word_t     reg2_i;
    ex_pkg::reg_addr_t wd_i;
    logic              wreg_i;
    ex_pkg::reg_addr_t mem_wd_o;
    logic              mem_wreg_o;
    ex_pkg::word_t     mem_wdata_o;
    ex_pkg::word_t     hi_o;
    ex_pkg::word_t     lo_o;

    logic              vec_valid;
    int                vec_id;
    ex_pkg::word_t     exp_wdata;
    logic              exp_wreg;
    logic              exp_hilo;
    ex_pkg::word_t     exp_hi;
    ex_pkg::word_t     exp_lo;
    int                err_count;
    int                done_count;
    int                cycles;

    logic [31:0] v_op[NUM_VEC];
    logic [31:0] v_sel[NUM_VEC];
    logic [31:0] v_r1[NUM_VEC];
    logic [31:0] v_r2[NUM_VEC];
    logic [31:0] v_wd[NUM_VEC];
    logic [31:0] v_wreg[NUM_VEC];
    logic [31:0] v_wdata[NUM_VEC];
    logic [31:0] v_ewreg[NUM_VEC];
    logic [31:0] v_hilo[NUM_VEC];
    logic [31:0] v_hi[NUM_VEC];
    logic [31:0] v_lo[NUM_VEC];

    mips_ex_top mips_ex_top_inst (.*);

    ex_checker ex_checker_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .vec_valid_i  (vec_valid),
        .vec_id_i     (vec_id),
        .exp_wd_i     (wd_i),
        .exp_wdata_i  (exp_wdata),
        .exp_wreg_i   (exp_wreg),
        .exp_hilo_i   (exp_hilo),
        .exp_hi_i     (exp_hi),
        .exp_lo_i     (exp_lo),
        .mem_wd_i     (mem_wd_o),
        .mem_wreg_i   (mem_wreg_o),
        .mem_wdata_i  (mem_wdata_o),
        .hi_i         (hi_o),
        .lo_i         (lo_o),
        .err_count_o  (err_count),
        .done_count_o (done_count)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run exceeded %0d cycles, %0d vectors done",
                     MAX_CYCLES, done_count);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic drive_nop(input logic valid);
        @(negedge clk);
        aluop_i   = ex_pkg::OP_NOP;
        alusel_i  = ex_pkg::SEL_NOP;
        reg1_i    = '0;
        reg2_i    = '0;
        wd_i      = '0;
        wreg_i    = 1'b0;
        vec_valid = valid;
        vec_id    = -1;
        exp_wdata = '0;
        exp_wreg  = 1'b0;
        exp_hilo  = 1'b0;
    endtask

    task automatic drive_vector(input int i);
        @(negedge clk);
        aluop_i   = ex_pkg::aluop_t'(v_op[i][7:0]);
        alusel_i  = ex_pkg::alusel_t'(v_sel[i][2:0]);
        reg1_i    = v_r1[i];
        reg2_i    = v_r2[i];
        wd_i      = v_wd[i][4:0];
        wreg_i    = v_wreg[i][0];
        vec_valid = 1'b1;
        vec_id    = i;
        exp_wdata = v_wdata[i];
        exp_wreg  = v_ewreg[i][0];
        exp_hilo  = v_hilo[i][0];
        exp_hi    = v_hi[i];
        exp_lo    = v_lo[i];
    endtask

    // returns the number of vectors found
    task automatic read_vectors(output int nvec);
        int    fd;
        int    n;
        string line;
        nvec = 0;
        fd   = $fopen("tests/ex_testdata.hex", "r");
        if (fd == 0) begin
            $display("cannot open tests/ex_testdata.hex");
            return;
        end
        while (!$feof(fd) && nvec < NUM_VEC) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.substr(0, 1) == "//") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                        v_op[nvec], v_sel[nvec], v_r1[nvec], v_r2[nvec], v_wd[nvec],
                        v_wreg[nvec], v_wdata[nvec], v_ewreg[nvec], v_hilo[nvec],
                        v_hi[nvec], v_lo[nvec]);
            if (n == 11) nvec = nvec + 1;
        end
        $fclose(fd);
    endtask

    initial begin
        int  nvec;
        int  gaps;
        logic dep;
        logic short_data;
        clk        = 1'b0;
        rst_i      = 1'b1;
        aluop_i    = ex_pkg::OP_NOP;
        alusel_i   = ex_pkg::SEL_NOP;
        reg1_i     = '0;
        reg2_i     = '0;
        wd_i       = '0;
        wreg_i     = 1'b0;
        vec_valid  = 1'b0;
        vec_id     = -1;
        exp_wdata  = '0;
        exp_wreg   = 1'b0;
        exp_hilo   = 1'b0;
        cycles     = 0;
        exp_hi     = '0;
        exp_lo     = '0;
        short_data = 1'b0;
        void'($urandom(SEED));
        read_vectors(nvec);
        if (nvec < NUM_VEC) begin
            $display("test data too short: %0d of %0d vectors read", nvec, NUM_VEC);
            short_data = 1'b1;
        end
        repeat (RST_CYCLES) @(negedge clk);
        rst_i = 1'b0;
        for (int i = 0; i < nvec; i++) begin
            // moves read hi/lo through forwarding and go back to back
            dep = (v_op[i][7:0] == ex_pkg::OP_MFHI) || (v_op[i][7:0] == ex_pkg::OP_MFLO);
            gaps = dep ? 0 : int'($urandom % 3);
            repeat (gaps) drive_nop(1'b1);
            drive_vector(i);
        end
        drive_nop(1'b0);
        while (done_count < nvec) @(posedge clk);
        repeat (3) @(posedge clk);  // idle hold of hi/lo
        $display("vectors checked: %0d, mismatches: %0d, assertion failures: %0d",
                 done_count, err_count, mips_ex_top_inst.ex_assertions_inst.fail_count);
        if (err_count == 0 && !short_data &&
            mips_ex_top_inst.ex_assertions_inst.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
